//--- audio_mix/audio_mix_channel.sv
// One audio mixer channel with deglitch, Linux mix-in, stereo blend,
// attenuation and clamping
`timescale 1ns/1ps
`default_nettype none

module audio_mix_channel
	import sys_pkg::*;
(
	input  logic      clk,
	input  logic      resetd,
	input  att_t      i_att,
	input  mix_mode_t i_mix,
	input  logic      i_signed,
	input  sample_t   i_core,
	input  sample_t   i_linux,
	input  sample_t   i_pre,
	output sample_t   o_pre,
	output sample_t   o_out
);

	sample_t                               d1;
	sample_t                               d2;
	sample_t                               d3;
	sample_t                               core_s;
	logic signed [$bits(sample_t):0]       a1;
	logic signed [$bits(sample_t):0]       a2;
	logic signed [$bits(sample_t):0]       a3;
	logic signed [$bits(sample_t):0]       a4;
	logic signed [$bits(sample_t):0]       pre_ext;
	logic signed [$bits(sample_t):0]       linux_ext;

	assign pre_ext   = {i_pre[$bits(sample_t)-1], i_pre};
	assign linux_ext = {i_linux[$bits(sample_t)-1], i_linux};

	////////////////////////////////////////////////////////////////////////
	// Deglitch, a sample must hold for two delayed copies
	always_ff @(posedge clk) begin
		if (resetd) begin
			d1     <= '0;
			d2     <= '0;
			d3     <= '0;
			core_s <= '0;
		end else begin
			d1 <= i_core;
			d2 <= d1;
			d3 <= d2;
			if (d2 == d3) begin
				core_s <= d2;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Mix pipeline
	always_ff @(posedge clk) begin
		if (resetd) begin
			a1    <= '0;
			a2    <= '0;
			a3    <= '0;
			a4    <= '0;
			o_pre <= '0;
			o_out <= '0;
		end else begin
			// Unsigned input loses its LSB to stay positive in 17 bits
			a1 <= i_signed ? {core_s[$bits(sample_t)-1], core_s}
			               : {2'b00, core_s[$bits(sample_t)-1:1]};
			a2 <= a1 + linux_ext;

			// Half sum goes to the opposite channel
			o_pre <= a2[$bits(sample_t):1];

			case (i_mix)
				2'd0: a3 <= a2;
				2'd1: a3 <= a2 - (a2 >>> 3) + (pre_ext >>> 2);
				2'd2: a3 <= a2 - (a2 >>> 2) + (pre_ext >>> 1);
				default: a3 <= (a2 >>> 1) + pre_ext;
			endcase

			if (i_att[4]) begin
				a4 <= '0;
			end else begin
				a4 <= a3 >>> i_att[3:0];
			end

			// Saturate when bits 16 and 15 disagree
			o_out <= (a4[$bits(sample_t)] ^ a4[$bits(sample_t)-1])
			       ? {a4[$bits(sample_t)], {($bits(sample_t)-1){a4[$bits(sample_t)-1]}}}
			       : a4[$bits(sample_t)-1:0];
		end
	end

endmodule

`default_nettype wire

//--- common/sys_pkg.sv
// Shared widths, types, host command codes and reset defaults
// for the system-control block
`default_nettype none

package sys_pkg;

	////////////////////////////////////////////////////////////////////////
	// Types
	typedef logic [15:0] io_word_t;
	typedef logic [7:0]  cmd_code_t;
	typedef logic [11:0] coord_t;
	typedef logic [7:0]  aspect_t;
	typedef logic [15:0] sample_t;
	// Bit 4 mutes, bits 3:0 are the right-shift count
	typedef logic [4:0]  att_t;
	// 0 none, 1 light, 2 medium, 3 full mono
	typedef logic [1:0]  mix_mode_t;
	typedef logic [7:0]  led_vec_t;

	typedef enum logic {
		CMD_IDLE,
		CMD_ARGS
	} cmd_state_t;

	////////////////////////////////////////////////////////////////////////
	// Host commands
	localparam cmd_code_t CMD_VIDEO_TIMING = 8'h20;
	localparam cmd_code_t CMD_LED          = 8'h25;
	localparam cmd_code_t CMD_VOLUME       = 8'h26;
	localparam cmd_code_t CMD_VSET         = 8'h27;

	// Argument positions inside the video timing command
	localparam logic [3:0] VT_IDX_WIDTH  = 4'd0;
	localparam logic [3:0] VT_IDX_HEIGHT = 4'd4;
	localparam logic [3:0] VT_WORDS      = 4'd8;

	// 1920x1080 frame out of reset
	localparam coord_t DEFAULT_WIDTH  = 12'd1920;
	localparam coord_t DEFAULT_HEIGHT = 12'd1080;

endpackage

`default_nettype wire

//--- design/host_cmd_decoder.sv
// Host word strobe detection, command decoding, setting registers
// and main-board LED merge
`timescale 1ns/1ps
`default_nettype none

module host_cmd_decoder
	import sys_pkg::*;
(
	input  logic     clk,
	input  logic     resetd,
	input  logic     i_io_uio,
	input  logic     i_io_clk,
	input  io_word_t i_io_din,
	input  led_vec_t i_led_status,
	output coord_t   o_width,
	output coord_t   o_height,
	output coord_t   o_vset,
	output att_t     o_att,
	output led_vec_t o_led
);

	cmd_state_t                    state;
	cmd_code_t                     cmd;
	logic [$bits(VT_WORDS)-1:0]    arg_cnt;
	logic                          io_clk_q;
	logic                          strobe;
	led_vec_t                      led_overtake;
	led_vec_t                      led_state;

	// Rising edge of the host clock, one cycle late
	always_ff @(posedge clk) begin
		if (resetd) begin
			io_clk_q <= 1'b0;
			strobe   <= 1'b0;
		end else begin
			io_clk_q <= i_io_clk;
			strobe   <= ~io_clk_q & i_io_clk;
		end
	end

	////////////////////////////////////////////////////////////////////////
	// Command FSM and setting registers
	always_ff @(posedge clk) begin
		if (resetd) begin
			state        <= CMD_IDLE;
			cmd          <= '0;
			arg_cnt      <= '0;
			o_width      <= DEFAULT_WIDTH;
			o_height     <= DEFAULT_HEIGHT;
			o_vset       <= '0;
			o_att        <= '0;
			led_overtake <= '0;
			led_state    <= '0;
		end else if (!i_io_uio) begin
			// Transfer closed, next word is a command
			state <= CMD_IDLE;
		end else if (strobe) begin
			case (state)
				CMD_IDLE: begin
					state   <= CMD_ARGS;
					cmd     <= i_io_din[$bits(cmd_code_t)-1:0];
					arg_cnt <= '0;
				end
				CMD_ARGS: begin
					case (cmd)
						CMD_VIDEO_TIMING: begin
							// Porch and sync words are counted but dropped
							if (arg_cnt < VT_WORDS) begin
								arg_cnt <= arg_cnt + 1'b1;
								if (arg_cnt == VT_IDX_WIDTH) begin
									o_width <= i_io_din[$bits(coord_t)-1:0];
								end
								if (arg_cnt == VT_IDX_HEIGHT) begin
									o_height <= i_io_din[$bits(coord_t)-1:0];
								end
							end
						end
						CMD_LED: begin
							{led_overtake, led_state} <= i_io_din;
						end
						CMD_VOLUME: begin
							o_att <= i_io_din[$bits(att_t)-1:0];
						end
						CMD_VSET: begin
							o_vset <= i_io_din[$bits(coord_t)-1:0];
						end
						default: begin
						end
					endcase
				end
				default: begin
					state <= CMD_IDLE;
				end
			endcase
		end
	end

	// Host-forced bits win where overtake is set
	assign o_led = (led_overtake & led_state) | (~led_overtake & i_led_status);

endmodule

`default_nettype wire

//--- design/mister_sys_top.sv
// System-control top level with host decoder, window calculator
// and the two cross-coupled audio mixer channels
`timescale 1ns/1ps
`default_nettype none

module mister_sys_top
	import sys_pkg::*;
(
	input  logic      clk,
	input  logic      resetd,
	input  logic      i_io_uio,
	input  logic      i_io_clk,
	input  io_word_t  i_io_din,
	input  led_vec_t  i_led_status,
	input  aspect_t   i_arx,
	input  aspect_t   i_ary,
	input  logic      i_audio_signed,
	input  mix_mode_t i_audio_mix,
	input  sample_t   i_core_l,
	input  sample_t   i_core_r,
	input  sample_t   i_linux_l,
	input  sample_t   i_linux_r,
	output led_vec_t  o_led,
	output coord_t    o_hmin,
	output coord_t    o_hmax,
	output coord_t    o_vmin,
	output coord_t    o_vmax,
	output sample_t   o_audio_l,
	output sample_t   o_audio_r
);

	coord_t  width;
	coord_t  height;
	coord_t  vset;
	att_t    att;
	sample_t pre_l;
	sample_t pre_r;

	host_cmd_decoder host_cmd_decoder_i (
		.clk          (clk),
		.resetd       (resetd),
		.i_io_uio     (i_io_uio),
		.i_io_clk     (i_io_clk),
		.i_io_din     (i_io_din),
		.i_led_status (i_led_status),
		.o_width      (width),
		.o_height     (height),
		.o_vset       (vset),
		.o_att        (att),
		.o_led        (o_led)
	);

	video_window_calc video_window_calc_i (
		.clk      (clk),
		.resetd   (resetd),
		.i_width  (width),
		.i_height (height),
		.i_vset   (vset),
		.i_arx    (i_arx),
		.i_ary    (i_ary),
		.o_hmin   (o_hmin),
		.o_hmax   (o_hmax),
		.o_vmin   (o_vmin),
		.o_vmax   (o_vmax)
	);

	////////////////////////////////////////////////////////////////////////
	// Each channel blends in the other one's half sum
	audio_mix_channel audio_mix_l_i (
		.clk      (clk),
		.resetd   (resetd),
		.i_att    (att),
		.i_mix    (i_audio_mix),
		.i_signed (i_audio_signed),
		.i_core   (i_core_l),
		.i_linux  (i_linux_l),
		.i_pre    (pre_r),
		.o_pre    (pre_l),
		.o_out    (o_audio_l)
	);

	audio_mix_channel audio_mix_r_i (
		.clk      (clk),
		.resetd   (resetd),
		.i_att    (att),
		.i_mix    (i_audio_mix),
		.i_signed (i_audio_signed),
		.i_core   (i_core_r),
		.i_linux  (i_linux_r),
		.i_pre    (pre_l),
		.o_pre    (pre_r),
		.o_out    (o_audio_r)
	);

endmodule

`default_nettype wire

//--- mister_sys.f
common/sys_pkg.sv
design/host_cmd_decoder.sv
video_window/video_window_calc.sv
audio_mix/audio_mix_channel.sv
design/mister_sys_top.sv
verification/tb_mister_sys_top.sv

//--- run_sim.sh
#!/bin/bash
# Build and run the system-control testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 -Wno-fatal \
	--top-module tb_mister_sys_top \
	-f mister_sys.f \
	--Mdir obj_dir \
	-o sim_mister_sys

./obj_dir/sim_mister_sys

//--- verification/tb_mister_sys_top.sv
// Testbench for the system-control top level with host commands, LED merge,
// window bounds and audio mixer reference models
`timescale 1ns/1ps
`default_nettype none

module tb_mister_sys_top
	import sys_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 20000;

	logic      clk;
	logic      resetd;
	logic      io_uio;
	logic      io_clk;
	io_word_t  io_din;
	led_vec_t  led_status;
	aspect_t   arx;
	aspect_t   ary;
	logic      audio_signed;
	mix_mode_t audio_mix;
	sample_t   core_l;
	sample_t   core_r;
	sample_t   linux_l;
	sample_t   linux_r;
	led_vec_t  led;
	coord_t    hmin;
	coord_t    hmax;
	coord_t    vmin;
	coord_t    vmax;
	sample_t   audio_l;
	sample_t   audio_r;

	integer    seed;
	integer    cycle_cnt;
	// Settings the DUT should hold after the commands sent so far
	coord_t    cur_width;
	coord_t    cur_height;
	coord_t    cur_vset;
	att_t      cur_att;

	mister_sys_top mister_sys_top_i (
		.clk            (clk),
		.resetd         (resetd),
		.i_io_uio       (io_uio),
		.i_io_clk       (io_clk),
		.i_io_din       (io_din),
		.i_led_status   (led_status),
		.i_arx          (arx),
		.i_ary          (ary),
		.i_audio_signed (audio_signed),
		.i_audio_mix    (audio_mix),
		.i_core_l       (core_l),
		.i_core_r       (core_r),
		.i_linux_l      (linux_l),
		.i_linux_r      (linux_r),
		.o_led          (led),
		.o_hmin         (hmin),
		.o_hmax         (hmax),
		.o_vmin         (vmin),
		.o_vmax         (vmax),
		.o_audio_l      (audio_l),
		.o_audio_r      (audio_r)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("SOME TESTS FAILED");
			$fatal(1, "Timeout: test sequence still running after %0d cycles", TIMEOUT_CYCLES);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Reference models

	function automatic led_vec_t ref_led(input led_vec_t ov, input led_vec_t st,
			input led_vec_t core_st);
		led_vec_t res;
		for (int b = 0; b < $bits(led_vec_t); b++) begin
			res[b] = ov[b] ? st[b] : core_st[b];
		end
		return res;
	endfunction

	// Packed as hmin, hmax, vmin, vmax
	function automatic logic [47:0] ref_window(input coord_t w, input coord_t h,
			input coord_t vs, input aspect_t ax, input aspect_t ay);
		logic [19:0] wc;
		logic [19:0] hc;
		coord_t      vw;
		coord_t      vh;
		coord_t      hmin_e;
		coord_t      vmin_e;
		if ((ax == '0) || (ay == '0)) begin
			return {12'd0, w - 12'd1, 12'd0, h - 12'd1};
		end
		wc = (20'((vs != '0) ? vs : h) * 20'(ax)) / 20'(ay);
		hc = (20'(w) * 20'(ay)) / 20'(ax);
		vw = ((vs == '0) && (wc > 20'(w))) ? w : wc[11:0];
		vh = (vs != '0) ? vs : ((hc < 20'(h)) ? hc[11:0] : h);
		hmin_e = (w - vw) >> 1;
		vmin_e = (h - vh) >> 1;
		return {hmin_e, hmin_e + vw - 12'd1, vmin_e, vmin_e + vh - 12'd1};
	endfunction

	function automatic logic signed [16:0] widen_sum(input sample_t core, input sample_t lin,
			input logic sgn);
		logic signed [16:0] wide;
		wide = sgn ? {core[15], core} : ({1'b0, core} >> 1);
		return wide + {lin[15], lin};
	endfunction

	function automatic sample_t blend_out(input logic signed [16:0] sum, input sample_t pre,
			input mix_mode_t mode, input att_t at);
		logic signed [16:0] pre_w;
		logic signed [16:0] mixed;
		logic signed [16:0] scaled;
		sample_t            res;
		pre_w = {pre[15], pre};
		case (mode)
			2'd0: mixed = sum;
			2'd1: mixed = sum - (sum >>> 3) + (pre_w >>> 2);
			2'd2: mixed = sum - (sum >>> 2) + (pre_w >>> 1);
			default: mixed = (sum >>> 1) + pre_w;
		endcase
		scaled = at[4] ? 17'sd0 : (mixed >>> at[3:0]);
		if (scaled > 17'sd32767) begin
			res = 16'h7fff;
		end else if (scaled < -17'sd32768) begin
			res = 16'h8000;
		end else begin
			res = scaled[15:0];
		end
		return res;
	endfunction

	// Packed as left, right
	function automatic logic [31:0] ref_mix(input sample_t cl, input sample_t cr,
			input sample_t ll, input sample_t lr, input logic sgn, input mix_mode_t mode,
			input att_t at);
		logic signed [16:0] sum_l;
		logic signed [16:0] sum_r;
		sample_t            half_l;
		sample_t            half_r;
		sum_l  = widen_sum(cl, ll, sgn);
		sum_r  = widen_sum(cr, lr, sgn);
		half_l = 16'(sum_l >>> 1);
		half_r = 16'(sum_r >>> 1);
		return {blend_out(sum_l, half_r, mode, at), blend_out(sum_r, half_l, mode, at)};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Compare, host pacing and settle helpers

	task automatic check(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, expected);
			$display("SOME TESTS FAILED");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	// High for two cycles, then low for two
	task automatic send_word(input io_word_t w);
		@(posedge clk);
		io_din <= w;
		io_clk <= 1'b1;
		repeat (2) @(posedge clk);
		io_clk <= 1'b0;
		repeat (2) @(posedge clk);
	endtask

	task automatic open_command(input cmd_code_t code);
		@(posedge clk);
		io_uio <= 1'b1;
		send_word({8'h00, code});
	endtask

	task automatic close_command();
		@(posedge clk);
		io_uio <= 1'b0;
		repeat (2) @(posedge clk);
	endtask

	task automatic drive_samples(input sample_t cl, input sample_t cr, input sample_t ll,
			input sample_t lr);
		@(posedge clk);
		core_l  <= cl;
		core_r  <= cr;
		linux_l <= ll;
		linux_r <= lr;
	endtask

	task automatic verify_window();
		logic [47:0] exp_b;
		repeat (16) @(posedge clk);
		@(negedge clk);
		exp_b = ref_window(cur_width, cur_height, cur_vset, arx, ary);
		check("o_hmin", 32'(hmin), 32'(exp_b[47:36]));
		check("o_hmax", 32'(hmax), 32'(exp_b[35:24]));
		check("o_vmin", 32'(vmin), 32'(exp_b[23:12]));
		check("o_vmax", 32'(vmax), 32'(exp_b[11:0]));
	endtask

	task automatic verify_audio();
		logic [31:0] exp_a;
		repeat (12) @(posedge clk);
		@(negedge clk);
		exp_a = ref_mix(core_l, core_r, linux_l, linux_r, audio_signed, audio_mix, cur_att);
		check("o_audio_l", 32'(audio_l), 32'(exp_a[31:16]));
		check("o_audio_r", 32'(audio_r), 32'(exp_a[15:0]));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		int       i;
		int       j;
		int       m;
		int       s;
		io_word_t word;
		aspect_t  ax_tmp;
		seed         = 32'h5562457f;
		cycle_cnt    = 0;
		clk          = 1'b0;
		resetd       = 1'b1;
		io_uio       = 1'b0;
		io_clk       = 1'b0;
		io_din       = '0;
		led_status   = '0;
		arx          = '0;
		ary          = '0;
		audio_signed = 1'b0;
		audio_mix    = '0;
		core_l       = '0;
		core_r       = '0;
		linux_l      = '0;
		linux_r      = '0;
		cur_width    = DEFAULT_WIDTH;
		cur_height   = DEFAULT_HEIGHT;
		cur_vset     = '0;
		cur_att      = '0;
		repeat (8) @(posedge clk);
		resetd <= 1'b0;

		// Out of reset the core owns every LED
		for (i = 0; i < 8; i++) begin
			@(posedge clk);
			led_status <= 8'($random(seed));
			@(negedge clk);
			check("o_led", 32'(led), 32'(ref_led(8'h00, 8'h00, led_status)));
		end
		verify_window();

		open_command(CMD_LED);
		for (i = 0; i < 6; i++) begin
			word = 16'($random(seed));
			send_word(word);
			for (j = 0; j < 4; j++) begin
				@(posedge clk);
				led_status <= 8'($random(seed));
				@(negedge clk);
				check("o_led", 32'(led), 32'(ref_led(word[15:8], word[7:0], led_status)));
			end
		end
		close_command();

		// Video timing with one extra word past the counted ones
		cur_width  = 12'd1024 + 12'($random(seed) & 1023);
		cur_height = 12'd200 + 12'($random(seed) & 511);
		open_command(CMD_VIDEO_TIMING);
		for (i = 0; i <= int'(VT_WORDS); i++) begin
			if (i == int'(VT_IDX_WIDTH)) begin
				send_word(16'(cur_width));
			end else if (i == int'(VT_IDX_HEIGHT)) begin
				send_word(16'(cur_height));
			end else begin
				send_word(16'($random(seed)));
			end
		end
		for (i = 0; i < 6; i++) begin
			@(posedge clk);
			arx <= 8'(($random(seed) & 127) + 1);
			ary <= 8'(($random(seed) & 127) + 1);
			verify_window();
		end
		close_command();
		@(posedge clk);
		ary <= '0;
		verify_window();

		// Fixed vertical size with aspect kept at or below 1:1
		for (i = 0; i < 4; i++) begin
			cur_vset = 12'd100 + 12'($random(seed) & 63);
			open_command(CMD_VSET);
			send_word(16'(cur_vset));
			close_command();
			ax_tmp = 8'(($random(seed) & 15) + 1);
			@(posedge clk);
			arx <= ax_tmp;
			ary <= ax_tmp + 8'($random(seed) & 15);
			verify_window();
		end

		// Every mixer mode and input format with full scale in the last two sets
		for (m = 0; m < 4; m++) begin
			for (s = 0; s < 2; s++) begin
				@(posedge clk);
				audio_mix    <= 2'(m);
				audio_signed <= s[0];
				for (i = 0; i < 6; i++) begin
					if (i == 4) begin
						drive_samples(16'h7fff, 16'h7fff, 16'h7fff, 16'h7fff);
					end else if (i == 5) begin
						drive_samples(16'h8000, 16'h8000, 16'h8000, 16'h8000);
					end else begin
						drive_samples(16'($random(seed)), 16'($random(seed)),
						              16'($random(seed)), 16'($random(seed)));
					end
					verify_audio();
				end
			end
		end

		// Shift counts 0 to 15, then muted with assorted shifts
		@(posedge clk);
		audio_signed <= 1'b1;
		audio_mix    <= 2'($random(seed));
		open_command(CMD_VOLUME);
		for (i = 0; i < 20; i++) begin
			cur_att = (i < 16) ? 5'(i) : 5'(16 + (i - 16) * 5);
			send_word({11'($random(seed)), cur_att});
			drive_samples(16'($random(seed)), 16'($random(seed)),
			              16'($random(seed)), 16'($random(seed)));
			verify_audio();
			if (cur_att[4]) begin
				check("o_audio_l", 32'(audio_l), 32'h0);
				check("o_audio_r", 32'(audio_r), 32'h0);
			end
		end
		close_command();

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- video_window/video_window_calc.sv
// Display window sequencer that fits the core aspect ratio
// into the output frame
`timescale 1ns/1ps
`default_nettype none

module video_window_calc
	import sys_pkg::*;
(
	input  logic    clk,
	input  logic    resetd,
	input  coord_t  i_width,
	input  coord_t  i_height,
	input  coord_t  i_vset,
	input  aspect_t i_arx,
	input  aspect_t i_ary,
	output coord_t  o_hmin,
	output coord_t  o_hmax,
	output coord_t  o_vmin,
	output coord_t  o_vmax
);

	// Wide enough for a coordinate times an aspect term
	logic [$bits(coord_t)+$bits(aspect_t)-1:0] wcalc;
	logic [$bits(coord_t)+$bits(aspect_t)-1:0] hcalc;
	logic [2:0] phase;
	coord_t     videow;
	coord_t     videoh;
	coord_t     hoff;
	coord_t     voff;

	// Centering offsets, half the unused border
	assign hoff = coord_t'((i_width - videow) >> 1);
	assign voff = coord_t'((i_height - videoh) >> 1);

	////////////////////////////////////////////////////////////////////////
	// Eight step sequence, quotients in step 0, size in 6, bounds in 7
	always_ff @(posedge clk) begin
		if (resetd) begin
			phase  <= '0;
			o_hmin <= '0;
			o_hmax <= DEFAULT_WIDTH - 1'b1;
			o_vmin <= '0;
			o_vmax <= DEFAULT_HEIGHT - 1'b1;
		end else begin
			phase <= phase + 1'b1;
			case (phase)
				3'd0: begin
					if ((i_arx != '0) && (i_ary != '0)) begin
						wcalc <= (i_vset != '0) ? (i_vset * i_arx) / i_ary
						                        : (i_height * i_arx) / i_ary;
						hcalc <= (i_width * i_ary) / i_arx;
					end else begin
						// No aspect given, show the full frame
						o_hmin <= '0;
						o_hmax <= i_width - 1'b1;
						o_vmin <= '0;
						o_vmax <= i_height - 1'b1;
						phase  <= '0;
					end
				end
				3'd6: begin
					videow <= ((i_vset == '0) && (wcalc > i_width)) ? i_width
					                                                : wcalc[$bits(coord_t)-1:0];
					if (i_vset != '0) begin
						videoh <= i_vset;
					end else begin
						videoh <= (hcalc > i_height) ? i_height : hcalc[$bits(coord_t)-1:0];
					end
				end
				3'd7: begin
					o_hmin <= hoff;
					o_hmax <= hoff + videow - 1'b1;
					o_vmin <= voff;
					o_vmax <= voff + videoh - 1'b1;
				end
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire
